// File: Makefile
# Verilator build and run of the execute stage testbench
VERILATOR ?= verilator
TOP       ?= tb_exu
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
ERR_LIMIT ?= 1000
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Regression failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the fail message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG ERR_LIMIT VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+$(ERR_LIMIT) > $(LOG) 2>&1; rc=$$?; \
	cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	    echo "simulation reported failure, see $(LOG)"; \
	    exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: files.f
verilog/exu_pkg.sv
verilog/exu_alu_shift.sv
verilog/exu_alu.sv
verilog/exu_decode.sv
verilog/exu_branch.sv
verilog/exu_top.sv
tb/exu_sva.sv
tb/tb_exu.sv

// File: tb/exu_sva.sv
/*
 * concurrent checks on exu_top attached with bind
 * stage timing, reset state, one-hot ALU control and illegal decode
 * fail_cnt counts the failed assertions
 */
`timescale 1ns/1ps

module exu_sva (
    input logic                clk,
    input logic                rst_n,
    input logic                issue_valid,
    input logic                ex_valid,
    input exu_pkg::ex_result_t ex_out,
    input exu_pkg::alu_ctrl_t  alu_ctrl,
    input logic                dec_illegal,
    input logic                dec_rd_we,
    input logic                br_taken
);
    int fail_cnt = 0;

    // fixed one cycle latency in both directions
    a_valid_follow: assert property (@(posedge clk) disable iff (!rst_n)
        1'b1 |=> (ex_valid == $past(issue_valid)))
    else begin
        fail_cnt++;
        $error("ex_valid does not follow issue_valid by one cycle");
    end

    a_reset_idle: assert property (@(posedge clk)
        !rst_n |-> (!ex_valid && !ex_out.rd_we && !ex_out.br_taken && !ex_out.illegal))
    else begin
        fail_cnt++;
        $error("stage outputs not cleared during reset");
    end

    // first edge out of reset
    a_reset_exit: assert property (@(posedge clk) $rose(rst_n) |-> !ex_valid)
    else begin
        fail_cnt++;
        $error("ex_valid high right after reset");
    end

    a_ctrl_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(alu_ctrl))
    else begin
        fail_cnt++;
        $error("ALU control has more than one bit set");
    end

    // illegal decode carries no write and no taken branch
    a_illegal_mask: assert property (@(posedge clk) disable iff (!rst_n)
        (issue_valid && dec_illegal) |-> (!dec_rd_we && !br_taken))
    else begin
        fail_cnt++;
        $error("illegal instruction decoded with rd_we or br_taken set");
    end

endmodule

bind exu_top exu_sva u_sva (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue_valid (issue_valid),
    .ex_valid    (ex_valid),
    .ex_out      (ex_out),
    .alu_ctrl    (dec.alu),
    .dec_illegal (dec.illegal),
    .dec_rd_we   (dec.rd_we),
    .br_taken    (br_taken)
);

// File: tb/tb_exu.sv
/*
 * testbench for exu_top, directed groups then random OP and OP-IMM
 * the reference model decodes each word by the RV32I rules
 * one cycle latency, results compared at the falling edge after it
 * rd and wb_data compared only when a write is expected
 */
`timescale 1ns/1ps

module tb_exu;
    import exu_pkg::*;

    typedef struct packed {
        ex_result_t res;
        logic       chk_tgt;      // branches and jumps only
    } exp_t;

    // corners 144, random 300, compares 32, shifts 384, branches 24, jumps 32, illegal 9
    localparam int          n_sched    = 144 + 300 + 32 + 384 + 24 + 32 + 9;
    localparam int          max_cycles = n_sched * 3 / 2 + 20;
    localparam logic [31:0] sign       = 32'h8000_0000;

    logic            clk = 1'b0;
    logic            rst_n;
    logic            issue_valid;
    logic [xlen-1:0] instr;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic            ex_valid;
    ex_result_t      ex_out;
    exp_t            exp_q [$];       // one entry at most, fixed latency
    logic [31:0]     corner [0:3];
    logic [31:0]     cmp_base [0:3];  // all fit a 12-bit immediate
    int              n_issued = 0;
    int              n_checked = 0;
    int              n_err = 0;
    int              cycles = 0;

    exu_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .instr       (instr),
        .pc          (pc),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val),
        .ex_valid    (ex_valid),
        .ex_out      (ex_out)
    );

    always #50 clk = ~clk;

    // encoders, rs1 = x1, rs2 = x2, random rd
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'($urandom), opc_op};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [6:0] opc);
        return {imm, 5'd1, f3, 5'($urandom), opc};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [6:0] opc);
        return {imm, 5'($urandom), opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'($urandom), opc_jal};
    endfunction

    function automatic logic [31:0] rand_pc();
        return $urandom & 32'hffff_fffc;   // word aligned
    endfunction

    // expected result straight from the ISA rules
    function automatic exp_t predict(input logic [31:0] ins, p, a, b);
        exp_t        e;
        logic [31:0] imm_i;
        logic [31:0] imm_u;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] op2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        ok;
        e     = '0;
        ok    = 1'b1;
        f3    = ins[14:12];
        f7    = ins[31:25];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_u = {ins[31:12], 12'h000};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        e.res.rd = ins[11:7];
        case (ins[6:0])
            opc_op, opc_op_imm: begin
                op2 = ins[5] ? b : imm_i;              // bit 5 tells OP from OP-IMM
                e.res.rd_we = 1'b1;
                case (f3)
                    3'b000: e.res.wb_data = (ins[5] && f7[5]) ? a - op2 : a + op2;
                    3'b001: e.res.wb_data = a << op2[4:0];
                    3'b010: e.res.wb_data = {31'b0, $signed(a) < $signed(op2)};
                    3'b011: e.res.wb_data = {31'b0, a < op2};
                    3'b100: e.res.wb_data = a ^ op2;
                    3'b101: begin
                        if (f7[5])
                            e.res.wb_data = $signed(a) >>> op2[4:0];
                        else
                            e.res.wb_data = a >> op2[4:0];
                    end
                    3'b110: e.res.wb_data = a | op2;
                    default: e.res.wb_data = a & op2;
                endcase
                if (ins[5])
                    ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
                else if (f3 == 3'b001)
                    ok = (f7 == 7'h00);
                else if (f3 == 3'b101)
                    ok = (f7 == 7'h00) || (f7 == 7'h20);
            end
            opc_lui: begin
                e.res.rd_we   = 1'b1;
                e.res.wb_data = imm_u;
            end
            opc_auipc: begin
                e.res.rd_we   = 1'b1;
                e.res.wb_data = p + imm_u;
            end
            opc_jal, opc_jalr: begin
                ok              = (ins[6:0] == opc_jal) || (f3 == 3'b000);
                e.chk_tgt       = 1'b1;
                e.res.rd_we     = 1'b1;
                e.res.wb_data   = p + 32'd4;          // link
                e.res.br_taken  = 1'b1;
                e.res.br_target = (ins[6:0] == opc_jal) ? p + imm_j
                                                        : (a + imm_i) & 32'hffff_fffe;
            end
            opc_branch: begin
                e.chk_tgt       = 1'b1;
                e.res.br_target = p + imm_b;          // taken or not
                case (f3)
                    3'b000: e.res.br_taken = (a == b);
                    3'b001: e.res.br_taken = (a != b);
                    3'b100: e.res.br_taken = ($signed(a) < $signed(b));
                    3'b101: e.res.br_taken = ($signed(a) >= $signed(b));
                    3'b110: e.res.br_taken = (a < b);
                    3'b111: e.res.br_taken = (a >= b);
                    default: ok = 1'b0;
                endcase
            end
            default: ok = 1'b0;
        endcase
        if (!ok) begin
            e             = '0;
            e.res.illegal = 1'b1;
        end
        return e;
    endfunction

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected)
        else begin
            n_err++;
            $display("[ERROR] %0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic issue(input logic [31:0] ins, p, a, b);
        @(posedge clk);
        #5;
        issue_valid = 1'b1;
        instr       = ins;
        pc          = p;
        rs1_val     = a;
        rs2_val     = b;
        n_issued++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #5;
            issue_valid = 1'b0;
        end
    endtask

    // prediction taken where the DUT samples
    always @(posedge clk) begin
        if (rst_n && issue_valid)
            exp_q.push_back(predict(instr, pc, rs1_val, rs2_val));
    end

    // outputs settled by the falling edge
    always @(negedge clk) begin
        exp_t e;
        check_field("ex_valid", 32'(exp_q.size() != 0), 32'(ex_valid));
        if (ex_valid && exp_q.size() != 0) begin
            e = exp_q.pop_front();
            check_field("rd_we", 32'(e.res.rd_we), 32'(ex_out.rd_we));
            check_field("br_taken", 32'(e.res.br_taken), 32'(ex_out.br_taken));
            check_field("illegal", 32'(e.res.illegal), 32'(ex_out.illegal));
            if (e.res.rd_we) begin
                check_field("rd", 32'(e.res.rd), 32'(ex_out.rd));
                check_field("wb_data", e.res.wb_data, ex_out.wb_data);
            end
            if (e.chk_tgt)
                check_field("br_target", e.res.br_target, ex_out.br_target);
            n_checked++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles) begin
            $display("timeout after %0d cycles, stimulus did not complete", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] v;
        logic [31:0] a;
        logic [31:0] b;
        logic [11:0] imm;
        logic [6:0]  f7;
        void'($urandom(21320));
        corner      = '{32'h0, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
        cmp_base    = '{32'h0, 32'h1, 32'h0000_07ff, 32'hffff_f800};
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        rs1_val     = '0;
        rs2_val     = '0;
        repeat (2) @(posedge clk);
        #5;
        rst_n = 1'b1;
        idle(2);

        // corner operands, sums wrap on the sign and all-ones patterns
        foreach (corner[i]) begin
            foreach (corner[j]) begin
                a = corner[i];
                b = corner[j];
                issue(r_type(7'h00, 3'b000), rand_pc(), a, b);
                issue(r_type(7'h20, 3'b000), rand_pc(), a, b);
                issue(r_type(7'h00, 3'b100), rand_pc(), a, b);
                issue(r_type(7'h00, 3'b110), rand_pc(), a, b);
                issue(r_type(7'h00, 3'b111), rand_pc(), a, b);
                issue(i_type(b[11:0], 3'b000, opc_op_imm), rand_pc(), a, b);
                issue(i_type(b[11:0], 3'b100, opc_op_imm), rand_pc(), a, b);
                issue(i_type(b[11:0], 3'b110, opc_op_imm), rand_pc(), a, b);
                issue(i_type(b[11:0], 3'b111, opc_op_imm), rand_pc(), a, b);
            end
        end
        idle(3);

        // random OP and OP-IMM, only legal funct7 values
        repeat (300) begin
            r   = $urandom;
            f7  = (r[4] && (r[2:0] == 3'b000 || r[2:0] == 3'b101)) ? 7'h20 : 7'h00;
            imm = r[31:20];
            if (r[2:0] == 3'b001 || r[2:0] == 3'b101)
                imm[11:5] = f7;                   // shift immediates
            if (r[3])
                issue(r_type(f7, r[2:0]), rand_pc(), $urandom, $urandom);
            else
                issue(i_type(imm, r[2:0], opc_op_imm), rand_pc(), $urandom, $urandom);
        end
        idle(3);

        // operands differing only in the sign bit
        foreach (cmp_base[i]) begin
            for (int o = 0; o < 2; o++) begin
                a = o ? cmp_base[i] ^ sign : cmp_base[i];
                b = o ? cmp_base[i] : cmp_base[i] ^ sign;
                issue(r_type(7'h00, 3'b010), rand_pc(), a, b);
                issue(r_type(7'h00, 3'b011), rand_pc(), a, b);
                issue(i_type(cmp_base[i][11:0], 3'b010, opc_op_imm), rand_pc(), a, b);
                issue(i_type(cmp_base[i][11:0], 3'b011, opc_op_imm), rand_pc(), a, b);
            end
        end
        idle(3);

        // every shift amount, junk in the upper bits of rs2
        for (int vi = 0; vi < 2; vi++) begin
            v = vi ? 32'h1234_5678 : 32'h8765_4321;
            for (int sh = 0; sh < 32; sh++) begin
                r = ($urandom & 32'hffff_ffe0) | 32'(sh);
                issue(r_type(7'h00, 3'b001), rand_pc(), v, r);
                issue(r_type(7'h00, 3'b101), rand_pc(), v, r);
                issue(r_type(7'h20, 3'b101), rand_pc(), v, r);
                issue(i_type({7'h00, 5'(sh)}, 3'b001, opc_op_imm), rand_pc(), v, r);
                issue(i_type({7'h00, 5'(sh)}, 3'b101, opc_op_imm), rand_pc(), v, r);
                issue(i_type({7'h20, 5'(sh)}, 3'b101, opc_op_imm), rand_pc(), v, r);
            end
        end
        idle(3);

        // branches, equal operands and pairs across the sign boundary
        for (int k = 0; k < 4; k++) begin
            a = (k == 0) ? $urandom : ((k == 2) ? 32'h1 : sign | {31'b0, k == 3});
            b = (k == 0) ? a : ((k == 2) ? sign : 32'h1);
            for (int f = 0; f < 8; f++) begin
                r = $urandom;
                if (f != 2 && f != 3)
                    issue(b_type({r[12:1], 1'b0}, 3'(f)), rand_pc(), a, b);
            end
        end
        idle(3);

        // upper immediates and jumps, jalr sums always odd here
        repeat (8) begin
            r = $urandom;
            issue(u_type(r[31:12], opc_lui), rand_pc(), $urandom, $urandom);
            issue(u_type(r[19:0], opc_auipc), rand_pc(), $urandom, $urandom);
            issue(j_type({r[20:1], 1'b0}), rand_pc(), $urandom, $urandom);
            issue(i_type({r[11:1], 1'b0}, 3'b000, opc_jalr), rand_pc(), $urandom | 32'h1,
                  $urandom);
        end
        idle(3);

        // illegal words, back to back
        issue(32'h0000_2003, rand_pc(), $urandom, $urandom);          // lw
        issue(32'h0020_a023, rand_pc(), $urandom, $urandom);          // sw
        issue(r_type(7'h01, 3'b000), rand_pc(), $urandom, $urandom);  // mul
        issue(r_type(7'h20, 3'b100), rand_pc(), $urandom, $urandom);
        issue(i_type(12'h403, 3'b001, opc_op_imm), rand_pc(), $urandom, $urandom);
        issue(i_type(12'h010, 3'b001, opc_jalr), rand_pc(), $urandom, $urandom);
        issue(b_type(13'h0010, 3'b010), rand_pc(), $urandom, $urandom);
        issue(32'h0000_0000, rand_pc(), $urandom, $urandom);
        issue(32'hffff_ffff, rand_pc(), $urandom, $urandom);
        idle(3);

        check_field("result count", 32'(n_issued), 32'(n_checked));
        $display("checked %0d results, %0d errors, %0d assertion failures",
                 n_checked, n_err, uut.u_sva.fail_cnt);
        if (n_err == 0 && uut.u_sva.fail_cnt == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// File: verilog/exu_alu.sv
/*
 * RV32I ALU with one shared adder for add, sub and the compares
 * ctrl must be one-hot or all zero, an all zero ctrl gives result 0
 * less is only meaningful for sub, slt and sltu
 * zero tests the adder output, so it is only valid for add/sub paths
 * shift amount is db[4:0]
 */
`timescale 1ns/1ps

module exu_alu (
    input  logic [exu_pkg::xlen-1:0] da,
    input  logic [exu_pkg::xlen-1:0] db,
    input  exu_pkg::alu_ctrl_t       ctrl,
    output logic                     less,
    output logic                     zero,
    output logic [exu_pkg::xlen-1:0] result
);
    import exu_pkg::*;

    logic            sub_add;     // 1 for subtract
    logic            unsigned_cmp;
    logic [xlen-1:0] db_inv;
    logic [xlen-1:0] add_sum;
    logic            add_carry;
    logic            add_ovf;
    logic [xlen-1:0] cmp_word;    // less zero-extended to a word
    logic [xlen-1:0] shift_out;

    assign sub_add      = ctrl.alu_sub | ctrl.alu_slt | ctrl.alu_sltu;
    assign unsigned_cmp = ctrl.alu_sltu;

    // two's complement subtract, invert b and carry in one
    assign db_inv = {xlen{sub_add}} ^ db;

    assign {add_carry, add_sum} = {1'b0, da} + {1'b0, db_inv} + {{xlen{1'b0}}, sub_add};

    // signed overflow when both inputs agree in sign and the sum does not
    assign add_ovf = (da[xlen-1] == db_inv[xlen-1]) && (da[xlen-1] != add_sum[xlen-1]);

    // no carry out of a - b means a < b unsigned
    assign less = unsigned_cmp ? ~add_carry : (add_ovf ^ add_sum[xlen-1]);
    assign zero = (add_sum == '0);

    assign cmp_word = {{(xlen-1){1'b0}}, less};

    exu_alu_shift u_shift (
        .din   (da),
        .shamt (db[4:0]),
        .left  (ctrl.alu_sll),
        .arith (ctrl.alu_sra),
        .dout  (shift_out)
    );

    // and-or select, relies on one-hot ctrl
    assign result = ({xlen{ctrl.alu_add}}      & add_sum)   |
                    ({xlen{ctrl.alu_sub}}      & add_sum)   |
                    ({xlen{ctrl.alu_slt}}      & cmp_word)  |
                    ({xlen{ctrl.alu_sltu}}     & cmp_word)  |
                    ({xlen{ctrl.alu_or}}       & (da | db)) |
                    ({xlen{ctrl.alu_and}}      & (da & db)) |
                    ({xlen{ctrl.alu_xor}}      & (da ^ db)) |
                    ({xlen{ctrl.alu_sll}}      & shift_out) |
                    ({xlen{ctrl.alu_srl}}      & shift_out) |
                    ({xlen{ctrl.alu_sra}}      & shift_out) |
                    ({xlen{ctrl.alu_explicit}} & db);         // lui pass-through

endmodule

// File: verilog/exu_alu_shift.sv
/*
 * log-structured barrel shifter, five conditional stages
 * left shifts reuse the right shifter on a bit-reversed word
 * arith fills with the sign bit, only meaningful for right shifts
 */
`timescale 1ns/1ps

module exu_alu_shift (
    input  logic [exu_pkg::xlen-1:0] din,
    input  logic [4:0]               shamt,
    input  logic                     left,
    input  logic                     arith,
    output logic [exu_pkg::xlen-1:0] dout
);
    import exu_pkg::*;

    logic            fill;          // bit shifted in from the top
    logic [xlen-1:0] rev_in;
    logic [xlen-1:0] rev_out;
    logic [xlen-1:0] stage [0:5];   // stage[0] in, stage[5] out

    function automatic logic [xlen-1:0] bit_rev(input logic [xlen-1:0] v);
        logic [xlen-1:0] r;
        for (int i = 0; i < xlen; i++) begin
            r[i] = v[xlen-1-i];
        end
        return r;
    endfunction

    assign fill     = arith & ~left & din[xlen-1];   // zero fill for logical
    assign rev_in   = bit_rev(din);
    assign stage[0] = left ? rev_in : din;

    // stage s shifts right by 2**s when shamt[s] is set
    for (genvar s = 0; s < 5; s++) begin : g_stage
        assign stage[s+1] = shamt[s] ? {{(1 << s){fill}}, stage[s][xlen-1:(1 << s)]}
                                     : stage[s];
    end

    assign rev_out = bit_rev(stage[5]);              // undo reversal for left
    assign dout    = left ? rev_out : stage[5];

endmodule

// File: verilog/exu_branch.sv
/*
 * branch decision and target adder
 * conditions use the ALU flags, so the decoder must have
 * selected sub for eq/ne, slt for lt/ge and sltu for ltu/geu
 * jal and jalr are always taken, br_none never
 * the target is computed for every kind, only meaningful when taken
 */
`timescale 1ns/1ps

module exu_branch (
    input  exu_pkg::br_kind_e        kind,
    input  logic                     less,
    input  logic                     zero,
    input  logic [exu_pkg::xlen-1:0] pc,
    input  logic [exu_pkg::xlen-1:0] rs1,
    input  logic [exu_pkg::xlen-1:0] imm,
    output logic                     taken,
    output logic [exu_pkg::xlen-1:0] target
);
    import exu_pkg::*;

    logic            is_jalr;
    logic [xlen-1:0] base;        // pc or rs1
    logic [xlen-1:0] sum;

    // condition from the flags of a - b
    always_comb begin
        case (kind)
            br_eq:   taken = zero;
            br_ne:   taken = ~zero;
            br_lt:   taken = less;       // signed via slt
            br_ge:   taken = ~less;
            br_ltu:  taken = less;       // unsigned via sltu
            br_geu:  taken = ~less;
            br_jal,
            br_jalr: taken = 1'b1;
            default: taken = 1'b0;       // br_none
        endcase
    end

    // own adder, the ALU is busy with the compare or the link value
    assign is_jalr = (kind == br_jalr);
    assign base    = is_jalr ? rs1 : pc;
    assign sum     = base + imm;

    // jalr clears bit 0 of rs1 + imm
    assign target = {sum[xlen-1:1], sum[0] & ~is_jalr};

endmodule

// File: verilog/exu_decode.sv
/*
 * RV32I decoder for the execute stage, purely combinational
 * covers OP, OP-IMM, LUI, AUIPC, JAL, JALR and the six branches
 * anything else, loads and stores included, is flagged illegal
 * rd_we is set for rd = x0 too, the register file drops those writes
 * an illegal word yields an all zero struct apart from illegal
 */
`timescale 1ns/1ps

module exu_decode (
    input  logic [exu_pkg::xlen-1:0] instr,
    output exu_pkg::ex_dec_t         dec
);
    import exu_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [4:0]      rd;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_j;
    logic            f7_zero;     // funct7 = 0000000
    logic            f7_alt;      // funct7 = 0100000, sub and sra
    logic            bad;

    assign opcode  = instr[6:0];
    assign rd      = instr[11:7];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);

    // immediates, sign from bit 31
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // funct3 to ALU bit, alt picks sub over add and sra over srl
    function automatic alu_ctrl_t f3_to_alu(input logic [2:0] f3, input logic alt);
        alu_ctrl_t c;
        c = '0;
        case (f3)
            3'b000: begin
                c.alu_add = ~alt;
                c.alu_sub = alt;
            end
            3'b001: c.alu_sll  = 1'b1;
            3'b010: c.alu_slt  = 1'b1;
            3'b011: c.alu_sltu = 1'b1;
            3'b100: c.alu_xor  = 1'b1;
            3'b101: begin
                c.alu_srl = ~alt;
                c.alu_sra = alt;
            end
            3'b110: c.alu_or   = 1'b1;
            default: c.alu_and = 1'b1;
        endcase
        return c;
    endfunction

    always_comb begin
        dec         = '0;
        dec.sel_b   = sel_b_rs2;
        dec.br_kind = br_none;
        bad         = 1'b0;
        case (opcode)
            opc_op: begin
                dec.alu   = f3_to_alu(funct3, f7_alt);
                dec.rd    = rd;
                dec.rd_we = 1'b1;
                // alt funct7 only for sub and sra
                bad = !(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            opc_op_imm: begin
                dec.alu   = f3_to_alu(funct3, f7_alt && funct3 == 3'b101);  // no subi
                dec.sel_b = sel_b_imm;
                dec.imm   = imm_i;
                dec.rd    = rd;
                dec.rd_we = 1'b1;
                if (funct3 == 3'b001)
                    bad = !f7_zero;
                else if (funct3 == 3'b101)
                    bad = !(f7_zero || f7_alt);
            end
            opc_lui: begin
                dec.alu.alu_explicit = 1'b1;
                dec.sel_b = sel_b_imm;
                dec.imm   = imm_u;
                dec.rd    = rd;
                dec.rd_we = 1'b1;
            end
            opc_auipc: begin
                dec.alu.alu_add = 1'b1;
                dec.sel_a_pc    = 1'b1;
                dec.sel_b       = sel_b_imm;
                dec.imm         = imm_u;
                dec.rd          = rd;
                dec.rd_we       = 1'b1;
            end
            opc_jal, opc_jalr: begin
                dec.alu.alu_add = 1'b1;                 // link = pc + 4
                dec.sel_a_pc    = 1'b1;
                dec.sel_b       = sel_b_four;
                dec.rd          = rd;
                dec.rd_we       = 1'b1;
                dec.imm         = (opcode == opc_jal) ? imm_j : imm_i;
                dec.br_kind     = (opcode == opc_jal) ? br_jal : br_jalr;
                bad             = (opcode == opc_jalr) && (funct3 != 3'b000);
            end
            opc_branch: begin
                dec.imm = imm_b;                        // b operand stays rs2
                case (funct3)
                    3'b000: {dec.alu.alu_sub, dec.br_kind}  = {1'b1, br_eq};
                    3'b001: {dec.alu.alu_sub, dec.br_kind}  = {1'b1, br_ne};
                    3'b100: {dec.alu.alu_slt, dec.br_kind}  = {1'b1, br_lt};
                    3'b101: {dec.alu.alu_slt, dec.br_kind}  = {1'b1, br_ge};
                    3'b110: {dec.alu.alu_sltu, dec.br_kind} = {1'b1, br_ltu};
                    3'b111: {dec.alu.alu_sltu, dec.br_kind} = {1'b1, br_geu};
                    default: bad = 1'b1;
                endcase
            end
            default: bad = 1'b1;                        // unsupported opcode
        endcase

        if (bad) begin
            dec         = '0;
            dec.illegal = 1'b1;
        end
    end

endmodule

// File: verilog/exu_pkg.sv
/*
 * shared widths, opcodes and types of the RV32I execute stage
 * xlen is fixed at 32, and the decoder and shifter assume it
 * alu_ctrl_t is one-hot, or all zero for an illegal instruction
 * only the opcodes handled by the execute stage are listed
 */
package exu_pkg;

    localparam int xlen = 32;                         // data path width

    // major opcodes, instr[6:0]
    localparam logic [6:0] opc_op     = 7'b0110011;   // register-register
    localparam logic [6:0] opc_op_imm = 7'b0010011;   // register-immediate
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;   // all six conditional kinds

    // one bit per ALU function, msb first
    typedef struct packed {
        logic alu_add;
        logic alu_sub;
        logic alu_slt;
        logic alu_sltu;
        logic alu_or;
        logic alu_and;
        logic alu_xor;
        logic alu_sll;
        logic alu_srl;
        logic alu_sra;
        logic alu_explicit;       // pass operand b, used by lui
    } alu_ctrl_t;

    typedef enum logic [3:0] {
        br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu, br_jal, br_jalr
    } br_kind_e;

    typedef enum logic [1:0] {
        sel_b_rs2, sel_b_imm, sel_b_four
    } sel_b_e;

    // decoder output, combinational from instr
    typedef struct packed {
        alu_ctrl_t       alu;
        logic            sel_a_pc;    // operand a is pc instead of rs1
        sel_b_e          sel_b;
        logic [xlen-1:0] imm;         // sign extended, per format
        logic [4:0]      rd;
        logic            rd_we;
        br_kind_e        br_kind;
        logic            illegal;
    } ex_dec_t;

    // registered stage output
    typedef struct packed {
        logic [4:0]      rd;
        logic            rd_we;
        logic [xlen-1:0] wb_data;
        logic            br_taken;
        logic [xlen-1:0] br_target;
        logic            illegal;
    } ex_result_t;

endpackage

// File: verilog/exu_top.sv
/*
 * execute stage of an in-order RV32I core
 * issue_valid is a one-cycle strobe, no back-pressure
 * one cycle latency, the consumer must take ex_out while ex_valid is high
 * instr, pc and the operands are sampled only with issue_valid
 * illegal instructions still produce ex_valid, with rd_we and br_taken low
 * no forwarding or hazard checks, operands arrive already resolved
 */
`timescale 1ns/1ps

module exu_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     issue_valid,
    input  logic [exu_pkg::xlen-1:0] instr,
    input  logic [exu_pkg::xlen-1:0] pc,
    input  logic [exu_pkg::xlen-1:0] rs1_val,
    input  logic [exu_pkg::xlen-1:0] rs2_val,
    output logic                     ex_valid,
    output exu_pkg::ex_result_t      ex_out
);
    import exu_pkg::*;

    ex_dec_t         dec;          // decoded controls
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_result;
    logic            alu_less;
    logic            alu_zero;
    logic            br_taken;
    logic [xlen-1:0] br_target;

    // stage register, control part
    logic            rd_we_q;
    logic            br_taken_q;
    logic            illegal_q;

    // stage register, payload part
    logic [4:0]      rd_q;
    logic [xlen-1:0] wb_data_q;
    logic [xlen-1:0] br_target_q;

    exu_decode u_decode (
        .instr (instr),
        .dec   (dec)
    );

    // operand a, pc for auipc and jumps
    assign op_a = dec.sel_a_pc ? pc : rs1_val;

    // operand b
    always_comb begin
        case (dec.sel_b)
            sel_b_imm:  op_b = dec.imm;
            sel_b_four: op_b = xlen'(4);      // link offset
            default:    op_b = rs2_val;       // OP and branches
        endcase
    end

    exu_alu u_alu (
        .da     (op_a),
        .db     (op_b),
        .ctrl   (dec.alu),
        .less   (alu_less),
        .zero   (alu_zero),
        .result (alu_result)
    );

    exu_branch u_branch (
        .kind   (dec.br_kind),
        .less   (alu_less),
        .zero   (alu_zero),
        .pc     (pc),
        .rs1    (rs1_val),
        .imm    (dec.imm),
        .taken  (br_taken),
        .target (br_target)
    );

    // control flops, cleared by reset and on idle cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid   <= 1'b0;
            rd_we_q    <= 1'b0;
            br_taken_q <= 1'b0;
            illegal_q  <= 1'b0;
        end else begin
            ex_valid   <= issue_valid;
            rd_we_q    <= issue_valid & dec.rd_we & ~dec.illegal;   // no write on illegal
            br_taken_q <= issue_valid & br_taken & ~dec.illegal;
            illegal_q  <= issue_valid & dec.illegal;
        end
    end

    // payload flops, load only on issue and hold otherwise
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            rd_q        <= dec.rd;
            wb_data_q   <= alu_result;      // also the link value for jumps
            br_target_q <= br_target;
        end
    end

    // assemble the result struct
    always_comb begin
        ex_out.rd        = rd_q;
        ex_out.rd_we     = rd_we_q;
        ex_out.wb_data   = wb_data_q;
        ex_out.br_taken  = br_taken_q;
        ex_out.br_target = br_target_q;
        ex_out.illegal   = illegal_q;
    end

endmodule
